//--- rtl/axil_regport_master.sv
// One outstanding write and one outstanding read; no write strobes; reads time out after 2**TIMEOUT-1 cycles
`timescale 1ns/1ns

module axil_regport_master import xbar_core_pkg::*; #(
  parameter int TIMEOUT = 6
) (
  input  logic                  i_bus_clk,
  input  logic                  i_bus_rst,
  // AXI4-Lite write channels
  input  logic [REG_AWIDTH-1:0] i_s_axi_awaddr,
  input  logic                  i_s_axi_awvalid,
  output logic                  o_s_axi_awready,
  input  logic [REG_DWIDTH-1:0] i_s_axi_wdata,
  input  logic                  i_s_axi_wvalid,
  output logic                  o_s_axi_wready,
  output logic [1:0]            o_s_axi_bresp,
  output logic                  o_s_axi_bvalid,
  input  logic                  i_s_axi_bready,
  // AXI4-Lite read channels
  input  logic [REG_AWIDTH-1:0] i_s_axi_araddr,
  input  logic                  i_s_axi_arvalid,
  output logic                  o_s_axi_arready,
  output logic [REG_DWIDTH-1:0] o_s_axi_rdata,
  output logic [1:0]            o_s_axi_rresp,
  output logic                  o_s_axi_rvalid,
  input  logic                  i_s_axi_rready,
  // Register port
  regport_if.master             reg_if
);

  axil_wr_state_t        wr_state;
  axil_rd_state_t        rd_state;
  logic [REG_AWIDTH-1:0] wr_addr_q;
  logic [REG_DWIDTH-1:0] wr_data_q;
  logic [REG_AWIDTH-1:0] rd_addr_q;
  logic                  rd_issue_q;
  logic [TIMEOUT-1:0]    rd_cnt;
  logic                  rd_done;
  logic [REG_DWIDTH-1:0] rdata_q;
  logic [1:0]            rresp_q;

  ////////////////////////////////////////////////////////////////////////////
  // Write path
  ////////////////////////////////////////////////////////////////////////////

  // Address and data accepted together, only when idle
  assign o_s_axi_awready = (wr_state == WR_IDLE) && i_s_axi_awvalid && i_s_axi_wvalid;
  assign o_s_axi_wready  = o_s_axi_awready;
  assign o_s_axi_bvalid  = (wr_state == WR_RESP);
  // Writes always complete, unmapped ones are simply dropped
  assign o_s_axi_bresp   = AXI_RESP_OKAY;

  assign reg_if.wr_req  = (wr_state == WR_ISSUE);
  assign reg_if.wr_addr = wr_addr_q;
  assign reg_if.wr_data = wr_data_q;

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      wr_state <= WR_IDLE;
    end else begin
      case (wr_state)
        WR_IDLE:  if (o_s_axi_awready) wr_state <= WR_ISSUE;
        // Single pulse on the register port
        WR_ISSUE: wr_state <= WR_RESP;
        // Hold bvalid until the host takes it
        WR_RESP:  if (i_s_axi_bready) wr_state <= WR_IDLE;
        default:  wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_bus_clk) begin
    if (o_s_axi_awready) begin
      wr_addr_q <= i_s_axi_awaddr;
      wr_data_q <= i_s_axi_wdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////////////////////

  assign o_s_axi_arready = (rd_state == RD_IDLE) && i_s_axi_arvalid;
  assign reg_if.rd_req   = rd_issue_q;
  assign reg_if.rd_addr  = rd_addr_q;
  assign o_s_axi_rvalid  = (rd_state == RD_DATA);
  assign o_s_axi_rdata   = rdata_q;
  assign o_s_axi_rresp   = rresp_q;

  // Response or counter expiry ends the wait
  assign rd_done = (rd_state == RD_WAIT) && (reg_if.rd_resp || (&rd_cnt));

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      rd_state   <= RD_IDLE;
      rd_issue_q <= 1'b0;
      rd_cnt     <= '0;
    end else begin
      // rd_req pulses the cycle after AR handshake
      rd_issue_q <= o_s_axi_arready;
      case (rd_state)
        RD_IDLE: begin
          rd_cnt <= '0;
          if (o_s_axi_arready) rd_state <= RD_WAIT;
        end
        RD_WAIT: begin
          rd_cnt <= rd_cnt + 1'b1;
          if (rd_done) rd_state <= RD_DATA;
        end
        RD_DATA: if (i_s_axi_rready) rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_bus_clk) begin
    if (o_s_axi_arready) begin
      rd_addr_q <= i_s_axi_araddr;
    end
    // Nobody claimed the address -> SLVERR with zero data
    if (rd_done) begin
      rdata_q <= reg_if.rd_resp ? reg_if.rd_data : '0;
      rresp_q <= reg_if.rd_resp ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
    end
  end

  // Each request is a single pulse, never stretched
  a_wr_req_pulse: assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
    reg_if.wr_req |=> !reg_if.wr_req)
    else $error("wr_req high on consecutive cycles");
  a_rd_req_pulse: assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
    reg_if.rd_req |=> !reg_if.rd_req)
    else $error("rd_req high on consecutive cycles");

endmodule

//--- rtl/core_global_regs.sv
// Exact-address decode of three words; writes elsewhere are ignored, scratch drives board pins
`timescale 1ns/1ns

module core_global_regs import xbar_core_pkg::*; #(
  parameter int NUM_PORTS = 4
) (
  input  logic       i_bus_clk,
  input  logic       i_bus_rst,
  regport_if.slave   reg_if,
  output logic [2:0] o_spi_mux,
  output logic       o_cpld_reset
);

  logic [REG_DWIDTH-1:0] scratch;
  logic                  rd_hit;
  logic [REG_DWIDTH-1:0] rd_mux;
  logic                  rd_resp_q;
  logic [REG_DWIDTH-1:0] rd_data_q;

  // Board control bits
  assign o_spi_mux    = scratch[2:0];
  assign o_cpld_reset = scratch[3];

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      scratch <= SCRATCH_RESET;
    end else if (reg_if.wr_req && (reg_if.wr_addr == REG_SCRATCH)) begin
      scratch <= reg_if.wr_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read decode
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    rd_hit = 1'b1;
    case (reg_if.rd_addr)
      REG_COMPAT:    rd_mux = COMPAT_NUM;
      REG_NUM_PORTS: rd_mux = REG_DWIDTH'(NUM_PORTS);
      REG_SCRATCH:   rd_mux = scratch;
      // Not ours, stay silent
      default: begin
        rd_hit = 1'b0;
        rd_mux = '0;
      end
    endcase
  end

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) rd_resp_q <= 1'b0;
    else           rd_resp_q <= reg_if.rd_req && rd_hit;
  end

  always_ff @(posedge i_bus_clk) begin
    if (reg_if.rd_req) rd_data_q <= rd_mux;
  end

  assign reg_if.rd_resp = rd_resp_q;
  assign reg_if.rd_data = rd_data_q;

endmodule

//--- rtl/pkt_crossbar_regport.sv
// NUM_PORTS 2..8; first beat is held until granted; grant lasts to tlast; no FIFOs inside
`timescale 1ns/1ns

module pkt_crossbar_regport import xbar_core_pkg::*; #(
  parameter int NUM_PORTS = 4
) (
  input  logic                              i_bus_clk,
  input  logic                              i_bus_rst,
  // Input streams
  input  logic [NUM_PORTS*STREAM_WIDTH-1:0] i_in_tdata,
  input  logic [NUM_PORTS-1:0]              i_in_tlast,
  input  logic [NUM_PORTS-1:0]              i_in_tvalid,
  output logic [NUM_PORTS-1:0]              o_in_tready,
  // Output streams
  output logic [NUM_PORTS*STREAM_WIDTH-1:0] o_out_tdata,
  output logic [NUM_PORTS-1:0]              o_out_tlast,
  output logic [NUM_PORTS-1:0]              o_out_tvalid,
  input  logic [NUM_PORTS-1:0]              i_out_tready,
  // Routing table access
  regport_if.slave                          reg_if
);

  localparam int PW        = $clog2(NUM_PORTS);
  localparam int TBL_DEPTH = 2 ** DST_WIDTH;
  localparam int TBL_BYTES = 4 * TBL_DEPTH;

  logic [PW-1:0]         route_tbl [TBL_DEPTH];
  logic                  rd_resp_q;
  logic [REG_DWIDTH-1:0] rd_data_q;

  in_state_t             in_state [NUM_PORTS];
  logic [PW-1:0]         dst_port [NUM_PORTS];
  logic [NUM_PORTS-1:0]  req      [NUM_PORTS];
  logic [NUM_PORTS-1:0]  busy;
  logic [PW-1:0]         owner    [NUM_PORTS];
  logic [PW-1:0]         last     [NUM_PORTS];
  logic [NUM_PORTS-1:0]  win_vld;
  logic [PW-1:0]         win_idx  [NUM_PORTS];
  logic [NUM_PORTS-1:0]  out_done;
  logic                  owner_clash;

  // Word-aligned address inside the table window
  function automatic logic tbl_hit(input logic [REG_AWIDTH-1:0] addr);
    logic [REG_AWIDTH-1:0] off;
    off = addr - XBAR_REG_BASE;
    return (addr >= XBAR_REG_BASE) && (off < TBL_BYTES) && (addr[1:0] == 2'b00);
  endfunction

  function automatic logic [DST_WIDTH-1:0] tbl_idx(input logic [REG_AWIDTH-1:0] addr);
    logic [REG_AWIDTH-1:0] off;
    off = addr - XBAR_REG_BASE;
    return off[DST_WIDTH+1:2];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Routing table and register access
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      // Default route maps d to d mod NUM_PORTS
      for (int d = 0; d < TBL_DEPTH; d++) route_tbl[d] <= PW'(d % NUM_PORTS);
    end else if (reg_if.wr_req && tbl_hit(reg_if.wr_addr)) begin
      route_tbl[tbl_idx(reg_if.wr_addr)] <= PW'(reg_if.wr_data % NUM_PORTS);
    end
  end

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) rd_resp_q <= 1'b0;
    else           rd_resp_q <= reg_if.rd_req && tbl_hit(reg_if.rd_addr);
  end

  always_ff @(posedge i_bus_clk) begin
    if (reg_if.rd_req) rd_data_q <= REG_DWIDTH'(route_tbl[tbl_idx(reg_if.rd_addr)]);
  end

  assign reg_if.rd_resp = rd_resp_q;
  assign reg_if.rd_data = rd_data_q;

  ////////////////////////////////////////////////////////////////////////////
  // Requests and round-robin arbitration
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    // Table lookup on the header beat
    for (int i = 0; i < NUM_PORTS; i++) begin
      dst_port[i] = route_tbl[i_in_tdata[i*STREAM_WIDTH +: DST_WIDTH]];
    end
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        req[o][i] = (in_state[i] == IN_HEADER) && i_in_tvalid[i] && (dst_port[i] == PW'(o));
      end
    end
  end

  always_comb begin
    int idx;
    for (int o = 0; o < NUM_PORTS; o++) begin
      win_vld[o] = 1'b0;
      win_idx[o] = '0;
      // Scan downward so the input right after the last winner is picked
      for (int k = NUM_PORTS; k >= 1; k--) begin
        idx = (int'(last[o]) + k) % NUM_PORTS;
        if (req[o][idx]) begin
          win_vld[o] = 1'b1;
          win_idx[o] = PW'(idx);
        end
      end
    end
  end

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      busy <= '0;
      for (int o = 0; o < NUM_PORTS; o++) begin
        owner[o] <= '0;
        last[o]  <= '0;
      end
      for (int i = 0; i < NUM_PORTS; i++) in_state[i] <= IN_HEADER;
    end else begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        if (busy[o]) begin
          // Release only after the tlast beat moves
          if (out_done[o]) begin
            busy[o]            <= 1'b0;
            in_state[owner[o]] <= IN_HEADER;
          end
        end else if (win_vld[o]) begin
          busy[o]              <= 1'b1;
          owner[o]             <= win_idx[o];
          last[o]              <= win_idx[o];
          in_state[win_idx[o]] <= IN_ROUTED;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath is combinational once granted
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    o_in_tready = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      o_out_tdata[o*STREAM_WIDTH +: STREAM_WIDTH] =
        i_in_tdata[owner[o]*STREAM_WIDTH +: STREAM_WIDTH];
      o_out_tlast[o]  = i_in_tlast[owner[o]];
      o_out_tvalid[o] = busy[o] && i_in_tvalid[owner[o]];
      out_done[o]     = o_out_tvalid[o] && i_out_tready[o] && o_out_tlast[o];
      // Back-pressure reaches only the owning input
      if (busy[o]) o_in_tready[owner[o]] = i_out_tready[o];
    end
  end

  // Same input owned by two busy outputs
  always_comb begin
    owner_clash = 1'b0;
    for (int a = 0; a < NUM_PORTS; a++) begin
      for (int b = a + 1; b < NUM_PORTS; b++) begin
        if (busy[a] && busy[b] && (owner[a] == owner[b])) owner_clash = 1'b1;
      end
    end
  end

  a_no_double_grant: assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
    !owner_clash)
    else $error("one input granted on two outputs");

endmodule

//--- rtl/regport_if.sv
// Strobe-only register port; requests are one-cycle pulses, owning slave answers next cycle
`timescale 1ns/1ns

interface regport_if import xbar_core_pkg::*; ();

  // Write request, address and data valid with the pulse
  logic                  wr_req;
  logic [REG_AWIDTH-1:0] wr_addr;
  logic [REG_DWIDTH-1:0] wr_data;

  // Read request and its response
  logic                  rd_req;
  logic [REG_AWIDTH-1:0] rd_addr;
  logic                  rd_resp;
  logic [REG_DWIDTH-1:0] rd_data;

  // Bridge or fan-out side
  modport master (
    output wr_req, wr_addr, wr_data,
    output rd_req, rd_addr,
    input  rd_resp, rd_data
  );

  // Register block side
  modport slave (
    input  wr_req, wr_addr, wr_data,
    input  rd_req, rd_addr,
    output rd_resp, rd_data
  );

endinterface

//--- rtl/regport_resp_mux.sv
// Two register slaves only; merged read response arrives one cycle after the slave answers
`timescale 1ns/1ns

module regport_resp_mux import xbar_core_pkg::*; (
  input  logic      i_bus_clk,
  input  logic      i_bus_rst,
  regport_if.slave  up,
  regport_if.master dn_glob,
  regport_if.master dn_xbar
);

  logic                  rd_resp_q;
  logic [REG_DWIDTH-1:0] rd_data_q;

  // Requests fan out unchanged, same cycle
  assign dn_glob.wr_req  = up.wr_req;
  assign dn_glob.wr_addr = up.wr_addr;
  assign dn_glob.wr_data = up.wr_data;
  assign dn_glob.rd_req  = up.rd_req;
  assign dn_glob.rd_addr = up.rd_addr;

  assign dn_xbar.wr_req  = up.wr_req;
  assign dn_xbar.wr_addr = up.wr_addr;
  assign dn_xbar.wr_data = up.wr_data;
  assign dn_xbar.rd_req  = up.rd_req;
  assign dn_xbar.rd_addr = up.rd_addr;

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) rd_resp_q <= 1'b0;
    else           rd_resp_q <= dn_glob.rd_resp | dn_xbar.rd_resp;
  end

  // Silent slaves contribute zero to the OR
  always_ff @(posedge i_bus_clk) begin
    rd_data_q <= (dn_glob.rd_resp ? dn_glob.rd_data : '0) |
                 (dn_xbar.rd_resp ? dn_xbar.rd_data : '0);
  end

  assign up.rd_resp = rd_resp_q;
  assign up.rd_data = rd_data_q;

  // Address ranges of the two slaves must not overlap
  a_one_responder: assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
    !(dn_glob.rd_resp && dn_xbar.rd_resp))
    else $error("both register slaves answered the same read");

endmodule

//--- rtl/xbar_core.sv
// Bus-clock core only; single clock and synchronous reset, register map fixed in the package
`timescale 1ns/1ns

module xbar_core import xbar_core_pkg::*; #(
  parameter int NUM_PORTS = 4,
  parameter int TIMEOUT   = 6
) (
  input  logic                              i_bus_clk,
  input  logic                              i_bus_rst,
  // AXI4-Lite host port
  input  logic [REG_AWIDTH-1:0]             i_s_axi_awaddr,
  input  logic                              i_s_axi_awvalid,
  output logic                              o_s_axi_awready,
  input  logic [REG_DWIDTH-1:0]             i_s_axi_wdata,
  input  logic                              i_s_axi_wvalid,
  output logic                              o_s_axi_wready,
  output logic [1:0]                        o_s_axi_bresp,
  output logic                              o_s_axi_bvalid,
  input  logic                              i_s_axi_bready,
  input  logic [REG_AWIDTH-1:0]             i_s_axi_araddr,
  input  logic                              i_s_axi_arvalid,
  output logic                              o_s_axi_arready,
  output logic [REG_DWIDTH-1:0]             o_s_axi_rdata,
  output logic [1:0]                        o_s_axi_rresp,
  output logic                              o_s_axi_rvalid,
  input  logic                              i_s_axi_rready,
  // Crossbar streams, NUM_PORTS lanes each
  input  logic [NUM_PORTS*STREAM_WIDTH-1:0] i_in_tdata,
  input  logic [NUM_PORTS-1:0]              i_in_tlast,
  input  logic [NUM_PORTS-1:0]              i_in_tvalid,
  output logic [NUM_PORTS-1:0]              o_in_tready,
  output logic [NUM_PORTS*STREAM_WIDTH-1:0] o_out_tdata,
  output logic [NUM_PORTS-1:0]              o_out_tlast,
  output logic [NUM_PORTS-1:0]              o_out_tvalid,
  input  logic [NUM_PORTS-1:0]              i_out_tready,
  // Board control
  output logic [2:0]                        o_spi_mux,
  output logic                              o_cpld_reset
);

  // Bridge side, then one branch per register slave
  regport_if reg_bus ();
  regport_if reg_glob ();
  regport_if reg_xbar ();

  ////////////////////////////////////////////////////////////////////////////
  // Register path
  ////////////////////////////////////////////////////////////////////////////
  axil_regport_master #(
    .TIMEOUT (TIMEOUT)
  ) regport_master_i (
    .i_bus_clk       (i_bus_clk),
    .i_bus_rst       (i_bus_rst),
    .i_s_axi_awaddr  (i_s_axi_awaddr),
    .i_s_axi_awvalid (i_s_axi_awvalid),
    .o_s_axi_awready (o_s_axi_awready),
    .i_s_axi_wdata   (i_s_axi_wdata),
    .i_s_axi_wvalid  (i_s_axi_wvalid),
    .o_s_axi_wready  (o_s_axi_wready),
    .o_s_axi_bresp   (o_s_axi_bresp),
    .o_s_axi_bvalid  (o_s_axi_bvalid),
    .i_s_axi_bready  (i_s_axi_bready),
    .i_s_axi_araddr  (i_s_axi_araddr),
    .i_s_axi_arvalid (i_s_axi_arvalid),
    .o_s_axi_arready (o_s_axi_arready),
    .o_s_axi_rdata   (o_s_axi_rdata),
    .o_s_axi_rresp   (o_s_axi_rresp),
    .o_s_axi_rvalid  (o_s_axi_rvalid),
    .i_s_axi_rready  (i_s_axi_rready),
    .reg_if          (reg_bus)
  );

  regport_resp_mux resp_mux_i (
    .i_bus_clk (i_bus_clk),
    .i_bus_rst (i_bus_rst),
    .up        (reg_bus),
    .dn_glob   (reg_glob),
    .dn_xbar   (reg_xbar)
  );

  core_global_regs #(
    .NUM_PORTS (NUM_PORTS)
  ) global_regs_i (
    .i_bus_clk    (i_bus_clk),
    .i_bus_rst    (i_bus_rst),
    .reg_if       (reg_glob),
    .o_spi_mux    (o_spi_mux),
    .o_cpld_reset (o_cpld_reset)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Packet crossbar
  ////////////////////////////////////////////////////////////////////////////
  pkt_crossbar_regport #(
    .NUM_PORTS (NUM_PORTS)
  ) crossbar_i (
    .i_bus_clk    (i_bus_clk),
    .i_bus_rst    (i_bus_rst),
    .i_in_tdata   (i_in_tdata),
    .i_in_tlast   (i_in_tlast),
    .i_in_tvalid  (i_in_tvalid),
    .o_in_tready  (o_in_tready),
    .o_out_tdata  (o_out_tdata),
    .o_out_tlast  (o_out_tlast),
    .o_out_tvalid (o_out_tvalid),
    .i_out_tready (i_out_tready),
    .reg_if       (reg_xbar)
  );

endmodule

//--- rtl/xbar_core_pkg.sv
// Register map is fixed at 16-bit byte addresses with 32-bit full-word access only
package xbar_core_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int REG_AWIDTH   = 16;
  localparam int REG_DWIDTH   = 32;
  localparam int STREAM_WIDTH = 64;
  // Destination sits in bits 7:0 of the first beat
  localparam int DST_WIDTH    = 8;

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////
  localparam logic [REG_DWIDTH-1:0] COMPAT_NUM    = 32'h0003_0001;

  // Global block offsets
  localparam logic [REG_AWIDTH-1:0] REG_COMPAT    = 16'h0000;
  localparam logic [REG_AWIDTH-1:0] REG_NUM_PORTS = 16'h0004;
  localparam logic [REG_AWIDTH-1:0] REG_SCRATCH   = 16'h0008;

  // Routing table, one word per destination
  localparam logic [REG_AWIDTH-1:0] XBAR_REG_BASE = 16'h0100;

  // SPI mux select 2, CPLD out of reset
  localparam logic [REG_DWIDTH-1:0] SCRATCH_RESET = 32'h0000_0002;

  // AXI response codes
  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

  ////////////////////////////////////////////////////////////////////////////
  // State encodings
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ISSUE,
    WR_RESP
  } axil_wr_state_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT,
    RD_DATA
  } axil_rd_state_t;

  // Crossbar input waits for a header, then streams once granted
  typedef enum logic {
    IN_HEADER,
    IN_ROUTED
  } in_state_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f xbar_core.f \
  --top-module tb_xbar_core || exit 1
out=$(./obj_dir/Vtb_xbar_core 2>&1)
echo "$out"
echo "$out" | grep -qx "Simulation PASSED" && exit 0 || exit 1

//--- tb/tb_xbar_core.sv
// Covers NUM_PORTS 4 and TIMEOUT 6 only; packet headers carry the source input in bits 15:8
`timescale 1ns/1ns

module tb_xbar_core import xbar_core_pkg::*; ();

  localparam int NP         = 4;
  localparam int SW         = STREAM_WIDTH;
  localparam int WAIT_LIMIT = 2000;

  logic                  bus_clk;
  logic                  bus_rst;
  logic [REG_AWIDTH-1:0] i_s_axi_awaddr;
  logic                  i_s_axi_awvalid;
  logic                  o_s_axi_awready;
  logic [REG_DWIDTH-1:0] i_s_axi_wdata;
  logic                  i_s_axi_wvalid;
  logic                  o_s_axi_wready;
  logic [1:0]            o_s_axi_bresp;
  logic                  o_s_axi_bvalid;
  logic                  i_s_axi_bready;
  logic [REG_AWIDTH-1:0] i_s_axi_araddr;
  logic                  i_s_axi_arvalid;
  logic                  o_s_axi_arready;
  logic [REG_DWIDTH-1:0] o_s_axi_rdata;
  logic [1:0]            o_s_axi_rresp;
  logic                  o_s_axi_rvalid;
  logic                  i_s_axi_rready;
  logic [NP*SW-1:0]      i_in_tdata;
  logic [NP-1:0]         i_in_tlast;
  logic [NP-1:0]         i_in_tvalid;
  logic [NP-1:0]         o_in_tready;
  logic [NP*SW-1:0]      o_out_tdata;
  logic [NP-1:0]         o_out_tlast;
  logic [NP-1:0]         o_out_tvalid;
  logic [NP-1:0]         i_out_tready;
  logic [2:0]            o_spi_mux;
  logic                  o_cpld_reset;

  // Reference model, own copy of the route table
  logic [1:0]            model_tbl [256];
  // Expected beats {tlast, data}, one queue per output and source input
  logic [SW:0]           exp_q [NP*NP][$];
  logic [NP-1:0]         active = '0;
  int                    cur_src [NP];
  logic                  rand_ready = 1'b0;

  xbar_core #(
    .NUM_PORTS (NP),
    .TIMEOUT   (6)
  ) i_xbar_core (
    .i_bus_clk (bus_clk),
    .i_bus_rst (bus_rst),
    .*
  );

  initial begin
    bus_clk = 1'b0;
    forever #4 bus_clk = ~bus_clk;
  end

  // Output ready, random or held high
  initial begin
    i_out_tready = '0;
    forever begin
      @(negedge bus_clk);
      i_out_tready = rand_ready ? NP'($urandom) : '1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////
  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
      else stop_with_failure($sformatf("CHECK FAILED %s got 0x%0h exp 0x%0h", name, got, exp));
  endtask

  // One clock, bounded
  task automatic tick_or_timeout(inout int n, input string what);
    @(posedge bus_clk);
    n++;
    if (n > WAIT_LIMIT) stop_with_failure({"timeout waiting for ", what});
  endtask

  task automatic write_reg(input logic [REG_AWIDTH-1:0] addr, input logic [REG_DWIDTH-1:0] data);
    int n;
    @(negedge bus_clk);
    i_s_axi_awaddr  = addr;
    i_s_axi_wdata   = data;
    i_s_axi_awvalid = 1'b1;
    i_s_axi_wvalid  = 1'b1;
    n = 0;
    do tick_or_timeout(n, "awready and wready");
    while (!(o_s_axi_awready && o_s_axi_wready));
    // Idle bridge takes both at once
    expect_eq("o_s_axi_awready latency", n, 1);
    @(negedge bus_clk);
    i_s_axi_awvalid = 1'b0;
    i_s_axi_wvalid  = 1'b0;
    i_s_axi_bready  = 1'b1;
    n = 0;
    do tick_or_timeout(n, "bvalid");
    while (!o_s_axi_bvalid);
    // wr_req one cycle after, bvalid one more
    expect_eq("o_s_axi_bvalid latency", n, 2);
    @(negedge bus_clk);
    i_s_axi_bready = 1'b0;
  endtask

  task automatic expect_read(input logic [REG_AWIDTH-1:0] addr,
                             input logic [REG_DWIDTH-1:0] exp_data, input logic [1:0] exp_resp);
    int n;
    @(negedge bus_clk);
    i_s_axi_araddr  = addr;
    i_s_axi_arvalid = 1'b1;
    n = 0;
    do tick_or_timeout(n, "arready");
    while (!o_s_axi_arready);
    @(negedge bus_clk);
    i_s_axi_arvalid = 1'b0;
    i_s_axi_rready  = 1'b1;
    n = 0;
    do tick_or_timeout(n, "rvalid");
    while (!o_s_axi_rvalid);
    expect_eq($sformatf("o_s_axi_rresp @0x%0h", addr), o_s_axi_rresp, exp_resp);
    expect_eq($sformatf("o_s_axi_rdata @0x%0h", addr), o_s_axi_rdata, exp_data);
    // Bridge, slave and merger stages
    if (exp_resp == AXI_RESP_OKAY) expect_eq("o_s_axi_rvalid latency", n, 4);
    @(negedge bus_clk);
    i_s_axi_rready = 1'b0;
  endtask

  // Table write; stored value is taken modulo the port count
  task automatic reroute(input int dst, input logic [REG_DWIDTH-1:0] val);
    logic [REG_AWIDTH-1:0] addr;
    addr = XBAR_REG_BASE + REG_AWIDTH'(4 * dst);
    write_reg(addr, val);
    model_tbl[dst] = 2'(val % NP);
    expect_read(addr, val % NP, AXI_RESP_OKAY);
  endtask

  task automatic send_packet(input int port, input logic [DST_WIDTH-1:0] dst, input int len);
    logic [SW-1:0] beat;
    int            out;
    int            n;
    out = int'(model_tbl[dst]);
    for (int b = 0; b < len; b++) begin
      // Header tags the source so the monitor can pick the queue
      if (b == 0) beat = {32'($urandom), 16'($urandom), 8'(port), dst};
      else        beat = {32'($urandom), 32'($urandom)};
      exp_q[out*NP+port].push_back({b == len - 1, beat});
      @(negedge bus_clk);
      i_in_tdata[port*SW +: SW] = beat;
      i_in_tlast[port]          = (b == len - 1);
      i_in_tvalid[port]         = 1'b1;
      n = 0;
      do tick_or_timeout(n, $sformatf("o_in_tready[%0d]", port));
      while (!o_in_tready[port]);
    end
    @(negedge bus_clk);
    i_in_tvalid[port] = 1'b0;
    i_in_tlast[port]  = 1'b0;
  endtask

  // Negative dst picks a random destination per packet
  task automatic send_burst(input int port, input int count, input int dst);
    for (int k = 0; k < count; k++) begin
      send_packet(port, (dst < 0) ? DST_WIDTH'($urandom) : DST_WIDTH'(dst), 1 + ($urandom % 6));
    end
  endtask

  task automatic wait_drained();
    int n;
    int left;
    n = 0;
    do begin
      tick_or_timeout(n, "expected beats to drain");
      left = 0;
      for (int q = 0; q < NP*NP; q++) left += exp_q[q].size();
    end while (left != 0 || active != '0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_out_beat(input int o);
    logic [SW:0] got;
    logic [SW:0] exp;
    int          src;
    got = {o_out_tlast[o], o_out_tdata[o*SW +: SW]};
    // Source locked for the whole packet, so interleaving shows up as a mismatch
    src = active[o] ? cur_src[o] : int'(got[15:8]);
    if (src >= NP || exp_q[o*NP+src].size() == 0)
      stop_with_failure($sformatf("unexpected beat on output %0d", o));
    exp = exp_q[o*NP+src].pop_front();
    expect_eq($sformatf("o_out_tdata[%0d]", o), got[SW-1:0], exp[SW-1:0]);
    expect_eq($sformatf("o_out_tlast[%0d]", o), got[SW], exp[SW]);
    cur_src[o] = src;
    active[o]  = !got[SW];
  endtask

  always @(posedge bus_clk) begin
    if (!bus_rst) begin
      for (int o = 0; o < NP; o++) begin
        if (o_out_tvalid[o] && i_out_tready[o]) check_out_beat(o);
      end
    end
  end

  a_reset_quiet: assert property (@(posedge bus_clk) $fell(bus_rst) |->
    !(o_s_axi_bvalid || o_s_axi_rvalid) && o_out_tvalid == '0 && o_in_tready == '0)
    else stop_with_failure($sformatf("CHECK FAILED bvalid/rvalid/tvalid/tready 0x%0h 0x%0h 0x%0h 0x%0h",
      o_s_axi_bvalid, o_s_axi_rvalid, o_out_tvalid, o_in_tready));
  a_bresp_okay: assert property (@(posedge bus_clk) disable iff (bus_rst)
    o_s_axi_bvalid |-> o_s_axi_bresp == AXI_RESP_OKAY)
    else stop_with_failure($sformatf("CHECK FAILED o_s_axi_bresp got 0x%0h", o_s_axi_bresp));
  a_slverr_zero: assert property (@(posedge bus_clk) disable iff (bus_rst)
    o_s_axi_rvalid && o_s_axi_rresp == AXI_RESP_SLVERR |-> o_s_axi_rdata == '0)
    else stop_with_failure($sformatf("CHECK FAILED o_s_axi_rdata got 0x%0h", o_s_axi_rdata));

  // Stalled output keeps its beat
  for (genvar g = 0; g < NP; g++) begin : g_lane
    a_out_hold: assert property (@(posedge bus_clk) disable iff (bus_rst)
      o_out_tvalid[g] && !i_out_tready[g] |=> o_out_tvalid[g] && $stable(o_out_tdata[g*SW +: SW]))
      else stop_with_failure($sformatf("CHECK FAILED o_out_tvalid[%0d] 0x%0h tdata 0x%0h",
        g, o_out_tvalid[g], o_out_tdata[g*SW +: SW]));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(32'h862b0bc8));
    bus_rst         = 1'b1;
    i_s_axi_awaddr  = '0;
    i_s_axi_awvalid = 1'b0;
    i_s_axi_wdata   = '0;
    i_s_axi_wvalid  = 1'b0;
    i_s_axi_bready  = 1'b0;
    i_s_axi_araddr  = '0;
    i_s_axi_arvalid = 1'b0;
    i_s_axi_rready  = 1'b0;
    i_in_tdata      = '0;
    i_in_tlast      = '0;
    i_in_tvalid     = '0;
    for (int d = 0; d < 256; d++) model_tbl[d] = 2'(d % NP);
    repeat (16) @(posedge bus_clk);
    @(negedge bus_clk);
    bus_rst = 1'b0;

    // Reset values
    expect_eq("o_spi_mux", o_spi_mux, 2);
    expect_eq("o_cpld_reset", o_cpld_reset, 0);
    expect_read(REG_COMPAT, COMPAT_NUM, AXI_RESP_OKAY);
    expect_read(REG_NUM_PORTS, NP, AXI_RESP_OKAY);
    expect_read(REG_SCRATCH, 32'h2, AXI_RESP_OKAY);

    // Scratch bits 2:0 to spi_mux, bit 3 to cpld_reset
    write_reg(REG_SCRATCH, 32'h0000_000D);
    expect_eq("o_spi_mux", o_spi_mux, 5);
    expect_eq("o_cpld_reset", o_cpld_reset, 1);
    expect_read(REG_SCRATCH, 32'h0000_000D, AXI_RESP_OKAY);

    // Unmapped address, read times out and write is dropped
    expect_read(16'h0040, 32'h0, AXI_RESP_SLVERR);
    write_reg(16'h0040, 32'hFFFF_FFF0);
    expect_read(REG_SCRATCH, 32'h0000_000D, AXI_RESP_OKAY);
    expect_eq("o_spi_mux", o_spi_mux, 5);

    // Default routes, all inputs busy, random back-pressure
    rand_ready = 1'b1;
    fork
      send_burst(0, 6, -1);
      send_burst(1, 6, -1);
      send_burst(2, 6, -1);
      send_burst(3, 6, -1);
    join
    wait_drained();

    // New routes, one of them written out of range
    reroute(1, 32'd3);
    reroute(6, 32'd0);
    reroute(42, 32'd5);
    reroute(255, 32'd2);
    fork
      send_burst(0, 3, 1);
      send_burst(1, 3, 6);
      send_burst(2, 3, 42);
      send_burst(3, 3, 255);
    join
    wait_drained();

    // All inputs fight for output 0
    fork
      send_burst(0, 4, 6);
      send_burst(1, 4, 6);
      send_burst(2, 4, 6);
      send_burst(3, 4, 6);
    join
    wait_drained();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- xbar_core.f
rtl/xbar_core_pkg.sv
rtl/regport_if.sv
rtl/axil_regport_master.sv
rtl/regport_resp_mux.sv
rtl/core_global_regs.sv
rtl/pkt_crossbar_regport.sv
rtl/xbar_core.sv
tb/tb_xbar_core.sv
